//--- Makefile
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert
LINT_FLAGS ?= --lint-only -Wall --timing
TOP       ?= smc_tb
FILELIST  ?= src.f
LOG       ?= sim.log
OBJ_DIR   ?= obj_dir

.PHONY: all run build lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "Simulation failed" $(LOG); then exit 1; fi
	@grep -q "Simulation passed" $(LOG)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- sim/smc_props.sv
`include "smc_config.svh"

module smc_props (
  input logic                   hclk,
  input logic                   arst_n,
  input smc_emi_pkg::emi_ctrl_t smc_ctrl
);

  timeunit 1ns;
  timeprecision 1ps;

  import smc_emi_pkg::*;

  logic       strb;     // Read or write strobe low
  logic       strb_q;
  logic [7:0] run_len;  // Cycles the strobe has been low

  assign strb = !smc_ctrl.n_rd || !smc_ctrl.n_wr;

  always_ff @(posedge hclk or negedge arst_n) begin
    if (!arst_n) begin
      run_len <= '0;
      strb_q  <= 1'b0;
    end else begin
      run_len <= strb ? run_len + 8'd1 : 8'd0;
      strb_q  <= strb;
    end
  end

  // --------------------------------------------------
  // Strobe timing
  // --------------------------------------------------

  cs_covers_strobe: assert property (@(posedge hclk) disable iff (!arst_n)
    smc_ctrl.n_cs |-> (smc_ctrl.n_rd && smc_ctrl.n_we == 4'hf))
    else $error("Strobe active without chip select");

  strobe_width: assert property (@(posedge hclk) disable iff (!arst_n)
    (strb_q && !strb) |-> (run_len == 8'(`SMC_WS + 1)))
    else $error("Strobe low period has wrong length");

  cs_lead: assert property (@(posedge hclk) disable iff (!arst_n)
    (strb && !strb_q) |-> (!$past(smc_ctrl.n_cs, `SMC_CSLE) &&
                           $past(smc_ctrl.n_cs, `SMC_CSLE + 1)))
    else $error("Chip select lead time wrong");

  rd_wr_exclusive: assert property (@(posedge hclk) disable iff (!arst_n)
    !(!smc_ctrl.n_rd && !smc_ctrl.n_wr))
    else $error("Read and write strobes low together");

endmodule

bind smc_emi_drive smc_props props_i (.hclk, .arst_n, .smc_ctrl);

//--- sim/smc_tb.sv
module smc_tb;

  timeunit 1ns;
  timeprecision 1ps;

  import smc_ahb_pkg::*;
  import smc_emi_pkg::*;

  localparam int TIMEOUT = 100;  // Cycles per wait

  logic      hclk;
  logic      arst_n;
  haddr_t    haddr;
  htrans_e   htrans;
  logic      hsel;
  logic      hwrite;
  hsize_e    hsize;
  hdata_t    hwdata;
  logic      hready;
  hdata_t    data_smc;
  hdata_t    smc_hrdata;
  logic      smc_hready;
  haddr_t    smc_addr;
  hdata_t    smc_data;
  emi_be_t   smc_n_be;
  emi_ctrl_t smc_ctrl;

  int      seed = 32'hbe68_e0f3;
  int      errors = 0;
  int      checks = 0;
  hdata_t  mem [256];     // External SRAM
  hdata_t  shadow [256];  // Expected contents
  emi_be_t exp_be;        // Lanes of the transfer in flight
  hdata_t  last_rdata;

  // Pending transfers
  haddr_t  q_addr[$];
  hsize_e  q_size[$];
  logic    q_write[$];
  hdata_t  q_wdata[$];
  string   q_name[$];
  // Results for the compare process
  hdata_t  exp_q[$];
  hdata_t  act_q[$];
  string   name_q[$];

  assign hready = smc_hready;  // Single slave on the bus

  smc_top dut_i (.*);

  always #10 hclk = ~hclk;

  // --------------------------------------------------
  // External memory model
  // --------------------------------------------------

  assign data_smc = !smc_ctrl.n_rd ? mem[smc_addr[9:2]] : '0;

  logic       wr_low_q = 1'b0;
  logic [3:0] n_we_q;
  haddr_t     addr_q;
  hdata_t     data_q;

  // Sampled mid-cycle, write lands on n_wr rising
  always @(negedge hclk) begin
    if (wr_low_q && smc_ctrl.n_wr) begin
      for (int i = 0; i < 4; i++) begin
        if (!n_we_q[i]) mem[addr_q[9:2]][8*i +: 8] = data_q[8*i +: 8];
      end
    end
    if (!smc_ctrl.n_wr) begin
      check("n_we", {28'h0, ~exp_be}, {28'h0, smc_ctrl.n_we});
      check("n_be", {28'h0, ~exp_be}, {28'h0, smc_n_be});
      check("n_ext_oe_wr", 32'h0, 32'(smc_ctrl.n_ext_oe));  // Bus driven on writes
    end
    if (!smc_ctrl.n_rd) begin
      check("n_ext_oe_rd", 32'h1, 32'(smc_ctrl.n_ext_oe));  // Bus released on reads
    end
    wr_low_q = !smc_ctrl.n_wr;
    n_we_q   = smc_ctrl.n_we;
    addr_q   = smc_addr;
    data_q   = smc_data;
  end

  // --------------------------------------------------
  // Reference model
  // --------------------------------------------------

  // Lane k belongs to the aligned 2**s byte block holding the address
  function automatic emi_be_t lanes(input haddr_t a, input hsize_e s);
    emi_be_t be;
    be = '0;
    for (int k = 0; k < 4; k++) begin
      if ((k >> s) == (int'(a[1:0]) >> s)) be[k] = 1'b1;
    end
    return be;
  endfunction

  function automatic hdata_t expect_read(input haddr_t a, input hsize_e s);
    emi_be_t be;
    hdata_t  r;
    be = lanes(a, s);
    r  = '0;
    for (int i = 0; i < 4; i++) begin
      if (be[i]) r[8*i +: 8] = shadow[a[9:2]][8*i +: 8];
    end
    return r;
  endfunction

  task automatic check(input string name, input hdata_t exp, input hdata_t act);
    checks++;
    if (exp !== act) begin
      errors++;
      $display("FAILED %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  // Compare process
  always @(negedge hclk) begin
    while (act_q.size() > 0) check(name_q.pop_front(), exp_q.pop_front(), act_q.pop_front());
  end

  // --------------------------------------------------
  // AHB master
  // --------------------------------------------------

  task automatic wait_ready();
    int cnt;
    cnt = 0;
    while (!smc_hready) begin
      @(negedge hclk);
      cnt++;
      if (cnt > TIMEOUT) begin
        $display("Timeout: smc_hready stayed low for %0d cycles", TIMEOUT);
        $display("Simulation failed");
        $finish;
      end
    end
  endtask

  task automatic queue_xfer(input string name, input haddr_t a, input hsize_e s,
                            input logic w, input hdata_t d);
    q_name.push_back(name);
    q_addr.push_back(a);
    q_size.push_back(s);
    q_write.push_back(w);
    q_wdata.push_back(d);
  endtask

  task automatic drive_addr(input int i);
    hsel   = 1'b1;
    htrans = NONSEQ;
    haddr  = q_addr[i];
    hsize  = q_size[i];
    hwrite = q_write[i];
  endtask

  // Pipelined: next address sits on the bus while hready is low
  task automatic run_xfers();
    int n;
    n = q_addr.size();
    @(negedge hclk);
    if (n > 0) drive_addr(0);
    for (int i = 0; i < n; i++) begin
      @(posedge hclk);  // Address phase taken
      @(negedge hclk);
      hwdata = q_wdata[i];
      exp_be = lanes(q_addr[i], q_size[i]);
      if (q_write[i]) begin
        for (int k = 0; k < 4; k++) begin
          if (exp_be[k]) shadow[q_addr[i][9:2]][8*k +: 8] = q_wdata[i][8*k +: 8];
        end
      end
      if (i + 1 < n) begin
        drive_addr(i + 1);
      end else begin
        hsel   = 1'b0;
        htrans = IDLE;
      end
      wait_ready();
      if (!q_write[i]) begin
        last_rdata = smc_hrdata;
        exp_q.push_back(expect_read(q_addr[i], q_size[i]));
        act_q.push_back(smc_hrdata);
        name_q.push_back(q_name[i]);
      end
    end
    q_name.delete();
    q_addr.delete();
    q_size.delete();
    q_write.delete();
    q_wdata.delete();
  endtask

  task automatic ahb_write(input haddr_t a, input hsize_e s, input hdata_t d);
    queue_xfer("write", a, s, 1'b1, d);
    run_xfers();
  endtask

  task automatic ahb_read(input string name, input haddr_t a, input hsize_e s,
                          output hdata_t d);
    queue_xfer(name, a, s, 1'b0, '0);
    run_xfers();
    d = last_rdata;
  endtask

  function automatic haddr_t rand_word_addr();
    return {22'h0, 8'($random(seed)), 2'b00};
  endfunction

  // --------------------------------------------------
  // Test sequence
  // --------------------------------------------------

  initial begin
    haddr_t a;
    hdata_t d;
    int     cnt;
    hclk   = 1'b0;
    arst_n = 1'b0;
    haddr  = '0;
    htrans = IDLE;
    hsel   = 1'b0;
    hwrite = 1'b0;
    hsize  = WORD;
    hwdata = '0;
    exp_be = '0;
    for (int i = 0; i < 256; i++) begin
      mem[i]    = '0;
      shadow[i] = '0;
    end
    repeat (4) @(posedge hclk);
    @(negedge hclk);
    arst_n = 1'b1;

    // Idle state after reset
    check("reset_hready", 32'h1, 32'(smc_hready));
    check("reset_ctrl", 32'hff, 32'(smc_ctrl));

    // Word write and read back
    for (int i = 0; i < 8; i++) begin
      a = rand_word_addr();
      ahb_write(a, WORD, $random(seed));
      ahb_read("word_rw", a, WORD, d);
    end

    // Partial writes merge into one word
    a = rand_word_addr();
    ahb_write(a, WORD, $random(seed));
    ahb_write(a + 1, BYTE, $random(seed));
    ahb_write(a + 2, HALF, $random(seed));
    ahb_write(a + 3, BYTE, $random(seed));
    ahb_read("merged_word", a, WORD, d);

    // Narrow reads
    for (int k = 0; k < 4; k++) ahb_read("byte_read", a + k, BYTE, d);
    ahb_read("half_read_lo", a, HALF, d);
    ahb_read("half_read_hi", a + 2, HALF, d);

    // Back-to-back NONSEQ
    for (int i = 0; i < 4; i++) begin
      a = rand_word_addr();
      queue_xfer("b2b_write", a, WORD, 1'b1, $random(seed));
      queue_xfer("b2b_byte", a + 2, BYTE, 1'b1, $random(seed));
      queue_xfer("b2b_read", a, WORD, 1'b0, '0);
      queue_xfer("b2b_half", a + 2, HALF, 1'b0, '0);
    end
    run_xfers();

    // Let the compare process drain
    cnt = 0;
    while (act_q.size() > 0) begin
      @(negedge hclk);
      cnt++;
      if (cnt > TIMEOUT) begin
        $display("Timeout: compare queue did not drain");
        $display("Simulation failed");
        $finish;
      end
    end

    for (int i = 0; i < 256; i++) check("mem_vs_shadow", shadow[i], mem[i]);

    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

//--- src.f
+incdir+verilog
verilog/smc_ahb_pkg.sv
verilog/smc_emi_pkg.sv
verilog/smc_ahb_slave.sv
verilog/smc_timing_seq.sv
verilog/smc_emi_drive.sv
verilog/smc_top.sv
sim/smc_props.sv
sim/smc_tb.sv

//--- verilog/smc_ahb_pkg.sv
package smc_ahb_pkg;

  // --------------------------------------------------
  // AHB-lite side types
  // --------------------------------------------------

  typedef logic [31:0] haddr_t;  // Byte address
  typedef logic [31:0] hdata_t;  // Read and write data

  // Transfer type
  typedef enum logic [1:0] {
    IDLE   = 2'b00,  // No transfer
    BUSY   = 2'b01,  // Master inserting idle cycle in a burst
    NONSEQ = 2'b10,  // First or single transfer
    SEQ    = 2'b11   // Burst continuation
  } htrans_e;

  // Transfer size
  // Larger sizes are not supported on a 32-bit bus
  typedef enum logic [2:0] {
    BYTE = 3'b000,  // 8 bits
    HALF = 3'b001,  // 16 bits
    WORD = 3'b010   // 32 bits
  } hsize_e;

endpackage

//--- verilog/smc_ahb_slave.sv
module smc_ahb_slave (
  input  logic                     hclk,
  input  logic                     arst_n,
  input  smc_ahb_pkg::haddr_t      haddr,
  input  smc_ahb_pkg::htrans_e     htrans,
  input  logic                     hsel,
  input  logic                     hwrite,
  input  smc_ahb_pkg::hsize_e      hsize,
  input  logic                     hready,      // Muxed ready from the bus
  input  smc_ahb_pkg::hdata_t      hwdata,
  input  smc_ahb_pkg::hdata_t      rdata,       // Latched external read data
  input  logic                     access_ack,
  output smc_emi_pkg::smc_access_t access,
  output logic                     access_req,
  output logic                     smc_hready,
  output smc_ahb_pkg::hdata_t      smc_hrdata
);

  import smc_ahb_pkg::*;
  import smc_emi_pkg::*;

  logic    addr_phase;  // Valid address phase this cycle
  logic    data_phase;  // Data phase pending, hwdata on the bus
  logic    start_req;   // Launch the access
  emi_be_t be_nxt;      // Lanes of the sampled transfer
  hdata_t  lane_mask;   // Read data mask from be

  // --------------------------------------------------
  // Address phase
  // --------------------------------------------------

  // Only sampled while not busy
  assign addr_phase = hsel && hready && smc_hready &&
                      (htrans == NONSEQ || htrans == SEQ);

  // Little endian lane select
  always_comb begin
    case (hsize)
      BYTE:    be_nxt = emi_be_t'(4'b0001 << haddr[1:0]);
      HALF:    be_nxt = haddr[1] ? 4'b1100 : 4'b0011;
      default: be_nxt = 4'b1111;  // Word and anything wider
    endcase
  end

  // Hold off req until the previous ack has dropped
  assign start_req = data_phase && !access_ack;

  // --------------------------------------------------
  // Handshake and hready
  // --------------------------------------------------

  always_ff @(posedge hclk or negedge arst_n) begin
    if (!arst_n) begin
      data_phase <= 1'b0;
      access_req <= 1'b0;
      smc_hready <= 1'b1;
    end else begin
      if (addr_phase) begin
        data_phase <= 1'b1;
        smc_hready <= 1'b0;  // Stall the data phase
      end else if (start_req) begin
        data_phase <= 1'b0;
        access_req <= 1'b1;
      end else if (access_req && access_ack) begin
        access_req <= 1'b0;  // Access finished
        smc_hready <= 1'b1;  // Completing cycle
      end
    end
  end

  // Access payload
  always_ff @(posedge hclk) begin
    if (addr_phase) begin
      access.addr  <= haddr;
      access.be    <= be_nxt;
      access.write <= hwrite;
    end
    if (start_req && access.write) begin
      access.wdata <= hwdata;  // Write data valid in data phase
    end
  end

  // --------------------------------------------------
  // Read data return
  // --------------------------------------------------

  // Unaddressed lanes read as zero
  always_comb begin
    for (int i = 0; i < 4; i++) begin
      lane_mask[8*i +: 8] = {8{access.be[i]}};
    end
  end

  assign smc_hrdata = rdata & lane_mask;  // Sampled by master while smc_hready high

endmodule

//--- verilog/smc_config.svh
`ifndef SMC_CONFIG_SVH
`define SMC_CONFIG_SVH

// --------------------------------------------------
// External bus cycle timing, in hclk cycles
// --------------------------------------------------

// Chip select low to strobe low
// Zero skips the lead phase
`define SMC_CSLE 1

// Wait states
// Strobe stays low for SMC_WS+1 cycles
`define SMC_WS 2

// Strobe high to chip select high
// Bus float time before the next access
// Zero skips the trail phase
`define SMC_CSTE 1

// All three must fit the 8-bit timing counter
// AHB latency is SMC_CSLE + SMC_WS + SMC_CSTE + 4 cycles

`endif

//--- verilog/smc_emi_drive.sv
module smc_emi_drive (
  input  logic                     hclk,
  input  logic                     arst_n,
  input  smc_emi_pkg::smc_access_t access,
  input  smc_emi_pkg::smc_state_e  state,
  input  logic                     latch,
  input  smc_ahb_pkg::hdata_t      data_smc,  // External read data
  output smc_ahb_pkg::haddr_t      smc_addr,
  output smc_ahb_pkg::hdata_t      smc_data,
  output smc_emi_pkg::emi_be_t     smc_n_be,  // Active low
  output smc_emi_pkg::emi_ctrl_t   smc_ctrl,
  output smc_ahb_pkg::hdata_t      rdata
);

  import smc_emi_pkg::*;

  logic      cs_phase;   // Lead, strobe or trail
  logic      strobe;     // Strobe phase
  emi_ctrl_t ctrl_nxt;

  assign cs_phase = state inside {ST_LEAD, ST_STROBE, ST_TRAIL};
  assign strobe   = (state == ST_STROBE);

  // --------------------------------------------------
  // Strobe decode
  // --------------------------------------------------

  always_comb begin
    ctrl_nxt.n_cs     = !cs_phase;
    ctrl_nxt.n_rd     = !(strobe && !access.write);
    ctrl_nxt.n_wr     = !(strobe && access.write);
    // Only the addressed lanes get a write strobe
    ctrl_nxt.n_we     = ~(access.be & {4{strobe && access.write}});
    ctrl_nxt.n_ext_oe = !(cs_phase && access.write);  // Drive bus on writes
  end

  // --------------------------------------------------
  // Output registers, one cycle behind state
  // --------------------------------------------------

  always_ff @(posedge hclk or negedge arst_n) begin
    if (!arst_n) begin
      smc_ctrl <= '1;  // All strobes inactive
      smc_n_be <= '1;
    end else begin
      smc_ctrl <= ctrl_nxt;
      smc_n_be <= cs_phase ? ~access.be : '1;
    end
  end

  // Address and write data
  always_ff @(posedge hclk) begin
    if (cs_phase) begin
      smc_addr <= access.addr;
      smc_data <= access.wdata;
    end
  end

  // Read capture on the last strobe cycle
  always_ff @(posedge hclk) begin
    if (latch) begin
      rdata <= data_smc;
    end
  end

endmodule

//--- verilog/smc_emi_pkg.sv
package smc_emi_pkg;

  import smc_ahb_pkg::haddr_t;
  import smc_ahb_pkg::hdata_t;

  // --------------------------------------------------
  // External memory interface types
  // --------------------------------------------------

  typedef logic [3:0] emi_be_t;  // Byte enables, active high internally
  typedef logic [7:0] tcount_t;  // Phase length counter

  // One external access, held while req is high
  typedef struct packed {
    haddr_t  addr;   // Byte address from AHB
    hdata_t  wdata;  // Write data, captured in data phase
    emi_be_t be;     // Lanes touched
    logic    write;  // 1 = write, 0 = read
  } smc_access_t;

  // External strobes, all active low
  typedef struct packed {
    logic       n_cs;      // Chip select
    logic       n_rd;      // Read strobe
    logic       n_wr;      // Write enable
    logic [3:0] n_we;      // Per-byte write strobes
    logic       n_ext_oe;  // Write data output enable
  } emi_ctrl_t;

  // Sequencer states
  typedef enum logic [2:0] {
    ST_IDLE,    // Waiting for req
    ST_LEAD,    // CS low, strobe not yet
    ST_STROBE,  // Strobe low for the wait states
    ST_TRAIL,   // Strobe high, CS held for float time
    ST_DONE     // ack high until req drops
  } smc_state_e;

endpackage

//--- verilog/smc_timing_seq.sv
`include "smc_config.svh"

module smc_timing_seq (
  input  logic                    hclk,
  input  logic                    arst_n,
  input  logic                    access_req,
  output logic                    access_ack,
  output smc_emi_pkg::smc_state_e state,
  output logic                    latch       // Read data capture pulse
);

  import smc_emi_pkg::*;

  // --------------------------------------------------
  // Phase lengths
  // --------------------------------------------------

  localparam bit HAS_LEAD  = (`SMC_CSLE > 0);
  localparam bit HAS_TRAIL = (`SMC_CSTE > 0);

  // Counters run down to zero, so load length minus one
  localparam tcount_t LEAD_LOAD   = HAS_LEAD  ? tcount_t'(`SMC_CSLE - 1) : '0;
  localparam tcount_t STROBE_LOAD = tcount_t'(`SMC_WS);
  localparam tcount_t TRAIL_LOAD  = HAS_TRAIL ? tcount_t'(`SMC_CSTE - 1) : '0;

  smc_state_e state_nxt;
  tcount_t    cnt;       // Cycles left in current phase
  tcount_t    cnt_nxt;
  logic       cnt_zero;  // Last cycle of the phase

  assign cnt_zero = (cnt == '0);

  // --------------------------------------------------
  // Next state
  // --------------------------------------------------

  always_comb begin
    state_nxt = state;
    cnt_nxt   = cnt_zero ? cnt : cnt - 1'b1;  // Count down by default

    case (state)
      ST_IDLE: begin
        if (access_req) begin
          if (HAS_LEAD) begin
            state_nxt = ST_LEAD;
            cnt_nxt   = LEAD_LOAD;
          end else begin
            state_nxt = ST_STROBE;  // No chip select lead
            cnt_nxt   = STROBE_LOAD;
          end
        end
      end

      ST_LEAD: begin
        if (cnt_zero) begin
          state_nxt = ST_STROBE;
          cnt_nxt   = STROBE_LOAD;
        end
      end

      ST_STROBE: begin
        if (cnt_zero) begin
          if (HAS_TRAIL) begin
            state_nxt = ST_TRAIL;
            cnt_nxt   = TRAIL_LOAD;
          end else begin
            state_nxt = ST_DONE;  // CS released with the strobe
          end
        end
      end

      ST_TRAIL: begin
        if (cnt_zero) begin
          state_nxt = ST_DONE;
        end
      end

      ST_DONE: begin
        if (!access_req) begin
          state_nxt = ST_IDLE;  // Slave has seen ack
        end
      end

      default: state_nxt = ST_IDLE;
    endcase
  end

  // --------------------------------------------------
  // Registers
  // --------------------------------------------------

  always_ff @(posedge hclk or negedge arst_n) begin
    if (!arst_n) begin
      state <= ST_IDLE;
      cnt   <= '0;
      latch <= 1'b0;
    end else begin
      state <= state_nxt;
      cnt   <= cnt_nxt;
      // Lines up with the last external strobe cycle
      latch <= (state == ST_STROBE) && cnt_zero;
    end
  end

  // Held high until req falls
  assign access_ack = (state == ST_DONE);

endmodule

//--- verilog/smc_top.sv
module smc_top (
  input  logic                   hclk,
  input  logic                   arst_n,
  input  smc_ahb_pkg::haddr_t    haddr,
  input  smc_ahb_pkg::htrans_e   htrans,
  input  logic                   hsel,
  input  logic                   hwrite,
  input  smc_ahb_pkg::hsize_e    hsize,
  input  smc_ahb_pkg::hdata_t    hwdata,
  input  logic                   hready,      // Muxed AHB ready
  input  smc_ahb_pkg::hdata_t    data_smc,    // EMI read data
  output smc_ahb_pkg::hdata_t    smc_hrdata,
  output logic                   smc_hready,
  output smc_ahb_pkg::haddr_t    smc_addr,
  output smc_ahb_pkg::hdata_t    smc_data,
  output smc_emi_pkg::emi_be_t   smc_n_be,    // Active low
  output smc_emi_pkg::emi_ctrl_t smc_ctrl
);

  import smc_ahb_pkg::*;
  import smc_emi_pkg::*;

  // --------------------------------------------------
  // Internal links
  // --------------------------------------------------

  smc_access_t access;      // Current access, held during req
  logic        access_req;
  logic        access_ack;
  smc_state_e  state;       // Sequencer phase
  logic        latch;       // Read capture pulse
  hdata_t      rdata;       // Latched read data

  smc_ahb_slave slave_i (
    .hclk, .arst_n, .haddr, .htrans, .hsel, .hwrite, .hsize, .hready, .hwdata,
    .rdata, .access_ack, .access, .access_req, .smc_hready, .smc_hrdata
  );

  smc_timing_seq seq_i (.hclk, .arst_n, .access_req, .access_ack, .state, .latch);

  smc_emi_drive drive_i (
    .hclk, .arst_n, .access, .state, .latch, .data_smc,
    .smc_addr, .smc_data, .smc_n_be, .smc_ctrl, .rdata
  );

endmodule
